/* tests/regfile_patterns.txt */
# test op rd id rs1 rs2 c1 c2, decimal, one cycle per line, c1 c2 = expected conflicts
# op 0 idle 1 issue 2 unit0 3 unit1 4 both (unit1 rd+1 id+1) 5 clear 6 inorder on 7 inorder off
1 1 5 1 0 0 0 0
1 1 6 2 5 6 1 0
1 2 5 1 6 0 1 0
1 3 6 2 5 0 0 0
1 2 0 3 5 6 0 0
1 7 0 0 0 5 0 0
2 1 7 3 0 0 0 0
2 1 8 4 7 0 1 0
2 2 7 3 8 7 1 0
2 0 0 0 8 0 0 0
2 5 0 0 7 8 0 1
2 7 0 0 8 7 0 0
3 1 9 5 0 0 0 0
3 3 9 5 9 9 0 0
4 1 10 6 0 0 0 0
4 1 10 7 10 0 1 0
4 2 10 6 10 0 1 0
4 6 0 0 10 0 1 0
4 2 10 6 10 0 1 0
4 7 0 0 10 0 1 0
4 2 10 7 10 0 0 0
5 1 11 0 0 0 0 0
5 1 12 1 11 0 1 0
5 4 11 0 11 12 0 1
5 7 0 0 12 11 0 0
5 7 0 0 12 11 0 0

/* verilog.f */
hw/regfile_pkg.sv
hw/inuse_scoreboard.sv
hw/register_file.sv
hw/writeback_arbiter.sv
hw/regfile_subsystem.sv
tests/regfile_assert.sv
tests/regfile_checker.sv
tests/regfile_tb.sv

/* Bender.yml */
package:
  name: regfile_subsystem

sources:
  - files:
      - hw/regfile_pkg.sv
      - hw/inuse_scoreboard.sv
      - hw/register_file.sv
      - hw/writeback_arbiter.sv
      - hw/regfile_subsystem.sv
  - target: test
    files:
      - tests/regfile_assert.sv
      - tests/regfile_checker.sv
      - tests/regfile_tb.sv

/* tests/regfile_tb.sv */
`default_nettype none

module regfile_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import regfile_pkg::*;

    typedef struct packed {
        int test;
        int op;
        int rd;
        int id;
        int rs1;
        int rs2;
        int c1;
        int c2;
    } pattern_t;  // one line of the pattern file

    logic         clk = 1'b0;
    logic         rst_n;
    decode_req_t  decode_req;
    decode_rsp_t  decode_rsp;
    unit_result_t unit0_result;
    unit_result_t unit1_result;
    logic         inorder;
    logic         inuse_clear;
    logic         unit1_busy;
    logic [1:0]   exp_conflict;
    int           test_num;
    int           errors;
    int           seed = 40;
    pattern_t     pats [$];

    always #10 clk = ~clk;  // 20 ns

    regfile_subsystem dut (.*);

    regfile_checker chk (.*);

    bind regfile_subsystem regfile_assert u_assert (.*);

    ////////////////////
    // stimulus helpers

    task automatic load_patterns();
        int       fd;
        string    line;
        pattern_t p;
        fd = $fopen("tests/regfile_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file tests/regfile_patterns.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines never scan as eight numbers
            if ($sscanf(line, "%d %d %d %d %d %d %d %d",
                        p.test, p.op, p.rd, p.id, p.rs1, p.rs2, p.c1, p.c2) == 8) begin
                pats.push_back(p);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        decode_req   = '0;
        unit0_result = '0;
        unit1_result = '0;
        inuse_clear  = 1'b0;
        exp_conflict = '0;
    endtask

    function automatic unit_result_t make_result(input int rd, input int id);
        unit_result_t r;
        r.valid   = 1'b1;
        r.rd_addr = reg_addr_t'(rd);
        r.id      = instr_id_t'(id);
        r.data    = $random(seed);
        return r;
    endfunction

    task automatic drive_pattern(input pattern_t p);
        drive_idle();
        test_num            = p.test;
        exp_conflict        = {p.c1[0], p.c2[0]};
        decode_req.rs1_addr = reg_addr_t'(p.rs1);
        decode_req.rs2_addr = reg_addr_t'(p.rs2);
        decode_req.uses_rs1 = (p.op != 0);  // idle leaves both sources unused
        decode_req.uses_rs2 = (p.op != 0);
        case (p.op)
            1: begin
                decode_req.future_rd_addr = reg_addr_t'(p.rd);
                decode_req.id             = instr_id_t'(p.id);
                decode_req.issued         = 1'b1;
            end
            2: unit0_result = make_result(p.rd, p.id);
            3: unit1_result = make_result(p.rd, p.id);
            4: begin
                unit0_result = make_result(p.rd, p.id);
                unit1_result = make_result(p.rd + 1, p.id + 1);  // tie on the port
            end
            5: inuse_clear = 1'b1;
            6: inorder = 1'b1;
            7: inorder = 1'b0;
            default: ;
        endcase
    endtask

    ////////////////////
    // main sequence

    initial begin
        rst_n    = 1'b0;
        inorder  = 1'b0;
        test_num = 0;
        drive_idle();
        load_patterns();
        fork
            begin
                #((pats.size() * 4 + 5 + 4) * 20);  // 4 cycles per line plus reset
                $display("watchdog expired before all patterns were applied");
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (pats[k]) begin
            @(negedge clk);
            // unit 1 stays quiet while its last result is parked
            while (unit1_busy && (pats[k].op == 3 || pats[k].op == 4)) begin
                drive_idle();
                @(negedge clk);
            end
            drive_pattern(pats[k]);
        end
        @(negedge clk);
        drive_idle();
        repeat (2) @(negedge clk);
        chk.report_end();
        if (pats.size() == 0) begin
            $display("no patterns were read, nothing was tested");
        end
        if (errors == 0 && pats.size() > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/regfile_checker.sv */
`default_nettype none

// reference model of the write port, registers and id claims
module regfile_checker (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire regfile_pkg::decode_req_t  decode_req,
    input  wire regfile_pkg::decode_rsp_t  decode_rsp,
    input  wire regfile_pkg::unit_result_t unit0_result,
    input  wire regfile_pkg::unit_result_t unit1_result,
    input  wire logic                      inorder,
    input  wire logic                      unit1_busy,
    input  wire logic [1:0]                exp_conflict,  // rs1, rs2 from the pattern file
    input  var  int                        test_num,
    output int                             errors
);

    timeunit 1ns;
    timeprecision 1ps;

    import regfile_pkg::*;

    data_t        regs  [reg_count];
    instr_id_t    claim [reg_count];  // latest issuing id per reg
    unit_result_t pend  [$];          // results still waiting for the port
    logic         busy_exp;           // unit 1 result parked behind another
    int           test_errs;
    int           passed;
    int           failed;
    int           last_test;

    task automatic check_field(input string name, input data_t exp, input data_t got);
        if (exp !== got) begin
            $display("FAILED %0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
            test_errs++;
        end
    endtask

    task automatic close_test();
        if (last_test != 0) begin
            $display("test %0d %s (%0d errors)", last_test,
                     (test_errs == 0) ? "passed" : "failed", test_errs);
            if (test_errs == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        test_errs = 0;
        last_test = 0;
    endtask

    task automatic report_end();
        close_test();
        $display("tests passed %0d failed %0d, %0d errors", passed, failed, errors);
    endtask

    ////////////////////
    // per cycle model

    // inputs change on the falling edge, so the rising edge sees a settled cycle
    always @(posedge clk or negedge rst_n) begin
        unit_result_t wb;
        logic         hit;
        logic         fwd1;
        logic         fwd2;
        logic         u1_in;
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i]  = '0;
                claim[i] = '0;
            end
            pend.delete();
            busy_exp = 1'b0;
        end else begin
            if (test_num != last_test) begin
                close_test();
                last_test = test_num;
            end
            check_field("unit1_busy", busy_exp, unit1_busy);
            // unit 0 ahead of unit 1, one write per cycle
            u1_in = 1'b0;
            if (unit0_result.valid && unit0_result.rd_addr != '0) begin
                pend.push_back(unit0_result);
            end
            if (unit1_result.valid && unit1_result.rd_addr != '0) begin
                pend.push_back(unit1_result);
                u1_in = 1'b1;
            end
            wb = '0;
            if (pend.size() > 0) begin
                wb = pend.pop_front();
            end
            busy_exp = u1_in && (pend.size() > 0);  // unit 1 lost the port this cycle
            hit  = wb.valid && (claim[wb.rd_addr] == wb.id);
            fwd1 = decode_req.uses_rs1 && hit && (decode_req.rs1_addr == wb.rd_addr);
            fwd2 = decode_req.uses_rs2 && hit && (decode_req.rs2_addr == wb.rd_addr);
            check_field("rs1_data", fwd1 ? wb.data : regs[decode_req.rs1_addr],
                        decode_rsp.rs1_data);
            check_field("rs2_data", fwd2 ? wb.data : regs[decode_req.rs2_addr],
                        decode_rsp.rs2_data);
            check_field("rs1_conflict", exp_conflict[1], decode_rsp.rs1_conflict);
            check_field("rs2_conflict", exp_conflict[0], decode_rsp.rs2_conflict);
            if (wb.valid && (hit || inorder)) begin
                regs[wb.rd_addr] = wb.data;  // stale id lands only in order mode
            end
            if (decode_req.issued && decode_req.future_rd_addr != '0) begin
                claim[decode_req.future_rd_addr] = decode_req.id;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/regfile_assert.sv */
`default_nettype none

// bound into regfile_subsystem, where the write port and unit1_busy meet the decode bus
module regfile_assert (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire regfile_pkg::decode_req_t decode_req,
    input wire regfile_pkg::decode_rsp_t decode_rsp,
    input wire regfile_pkg::wb_write_t   wb_write,
    input wire logic                     unit1_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    // r0 results are filtered in the arbiter
    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_write.valid_write |-> (wb_write.rd_addr != '0))
        else $error("write port raised for r0");

    busy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        unit1_busy |=> !unit1_busy)  // hold1 drains in one cycle
        else $error("unit1_busy held for two cycles");

    no_unused_conflict: assert property (@(posedge clk) disable iff (!rst_n)
        (!decode_req.uses_rs1 -> !decode_rsp.rs1_conflict) &&
        (!decode_req.uses_rs2 -> !decode_rsp.rs2_conflict))
        else $error("conflict reported on an unused source");

endmodule

`default_nettype wire

/* hw/regfile_subsystem.sv */
`default_nettype none

module regfile_subsystem (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire regfile_pkg::decode_req_t  decode_req,
    output regfile_pkg::decode_rsp_t      decode_rsp,
    input  wire regfile_pkg::unit_result_t unit0_result,
    input  wire regfile_pkg::unit_result_t unit1_result,
    input  wire logic                     inorder,
    input  wire logic                     inuse_clear,
    output logic                          unit1_busy
);

    import regfile_pkg::*;

    ////////////////////
    // internal buses

    wb_write_t wb_write;  // arbiter -> regfile, single write port
    fwd_req_t  fwd_req;   // masked read data + forward flags
    fwd_rsp_t  fwd_rsp;   // merged read data back

    writeback_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .unit0_result (unit0_result),
        .unit1_result (unit1_result),
        .wb_write     (wb_write),
        .fwd_req      (fwd_req),
        .fwd_rsp      (fwd_rsp),
        .unit1_busy   (unit1_busy)
    );

    register_file u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .inorder     (inorder),
        .inuse_clear (inuse_clear),
        .decode_req  (decode_req),
        .decode_rsp  (decode_rsp),
        .wb_write    (wb_write),
        .fwd_req     (fwd_req),
        .fwd_rsp     (fwd_rsp)
    );

endmodule

`default_nettype wire

/* hw/writeback_arbiter.sv */
`default_nettype none

// two units, one write port
// unit 0 wins a tie; unit 1 waits a cycle in hold1 and unit 0's next result
// slips one cycle through hold0 behind it
module writeback_arbiter (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire regfile_pkg::unit_result_t unit0_result,
    input  wire regfile_pkg::unit_result_t unit1_result,
    output regfile_pkg::wb_write_t        wb_write,
    input  wire regfile_pkg::fwd_req_t    fwd_req,
    output regfile_pkg::fwd_rsp_t         fwd_rsp,
    output logic                          unit1_busy
);

    import regfile_pkg::*;

    unit_result_t hold0;    // delayed unit 0 result
    unit_result_t hold1;    // unit 1 result that lost the tie
    unit_result_t hold0_n;
    unit_result_t hold1_n;
    unit_result_t sel;      // winner this cycle
    logic         u0_ok;
    logic         u1_ok;

    // r0 results never reach the port
    assign u0_ok = unit0_result.valid && (unit0_result.rd_addr != '0);
    assign u1_ok = unit1_result.valid && (unit1_result.rd_addr != '0);

    ////////////////////
    // select + next hold state

    always_comb begin
        sel     = '0;
        hold0_n = '0;
        hold1_n = '0;
        if (hold1.valid) begin
            sel     = hold1;
            hold0_n = hold0.valid ? hold0 : (u0_ok ? unit0_result : '0);  // unit 1 is quiet now
        end else if (hold0.valid) begin
            sel     = hold0;
            hold0_n = u0_ok ? unit0_result : '0;  // unit 0 stream stays one behind
            hold1_n = u1_ok ? unit1_result : '0;
        end else if (u0_ok) begin
            sel     = unit0_result;
            hold1_n = u1_ok ? unit1_result : '0;  // tie, park unit 1
        end else if (u1_ok) begin
            sel     = unit1_result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold0 <= '0;
            hold1 <= '0;
        end else begin
            hold0 <= hold0_n;
            hold1 <= hold1_n;
        end
    end

    assign unit1_busy = hold1.valid;  // unit 1 must not present next result

    ////////////////////
    // write port

    assign wb_write.valid_write = sel.valid;
    assign wb_write.rd_addr     = sel.rd_addr;
    assign wb_write.id          = sel.id;
    assign wb_write.rd_data     = sel.data;

    // array data arrives masked on forwarded ports, so OR is enough
    assign fwd_rsp.rs1_data_out = fwd_req.rs1_data_in | ({xlen{fwd_req.forward_rs1}} & sel.data);
    assign fwd_rsp.rs2_data_out = fwd_req.rs2_data_in | ({xlen{fwd_req.forward_rs2}} & sel.data);

endmodule

`default_nettype wire

/* hw/register_file.sv */
`default_nettype none

module register_file (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    inorder,      // commit regardless of id
    input  wire logic                    inuse_clear,
    input  wire regfile_pkg::decode_req_t decode_req,
    output regfile_pkg::decode_rsp_t     decode_rsp,
    input  wire regfile_pkg::wb_write_t  wb_write,
    output regfile_pkg::fwd_req_t        fwd_req,
    input  wire regfile_pkg::fwd_rsp_t   fwd_rsp
);

    import regfile_pkg::*;

    data_t     regs      [reg_count];
    instr_id_t in_use_by [reg_count];  // id of the last claimant per reg

    logic      rs1_inuse;
    logic      rs2_inuse;
    logic      rs1_fwd;
    logic      rs2_fwd;
    logic      id_match;   // wb id equals latest claim
    logic      claim;      // issue with a real destination
    instr_id_t wb_owner;

    // r0 never gets claimed, otherwise it would stall forever
    assign claim = decode_req.issued && (decode_req.future_rd_addr != '0);

    ////////////////////
    // storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write.valid_write && (id_match || inorder)) begin
            regs[wb_write.rd_addr] <= wb_write.rd_data;  // arbiter filters r0
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                in_use_by[i] <= '0;
            end
        end else if (claim) begin
            in_use_by[decode_req.future_rd_addr] <= decode_req.id;
        end
    end

    inuse_scoreboard u_inuse (
        .clk            (clk),
        .rst_n          (rst_n),
        .clr            (inuse_clear),
        .rs1_addr       (decode_req.rs1_addr),
        .rs2_addr       (decode_req.rs2_addr),
        .decode_rd_addr (decode_req.future_rd_addr),
        .wb_rd_addr     (wb_write.rd_addr),
        .issued         (claim),
        .completed      (id_match),  // only the latest claimant releases the reg
        .rs1_inuse      (rs1_inuse),
        .rs2_inuse      (rs2_inuse)
    );

    ////////////////////
    // forwarding detect

    assign wb_owner = in_use_by[wb_write.rd_addr];
    assign id_match = wb_write.valid_write && (wb_owner == wb_write.id);

    assign rs1_fwd = decode_req.uses_rs1 && id_match && (decode_req.rs1_addr == wb_write.rd_addr);
    assign rs2_fwd = decode_req.uses_rs2 && id_match && (decode_req.rs2_addr == wb_write.rd_addr);

    assign fwd_req.forward_rs1 = rs1_fwd;
    assign fwd_req.forward_rs2 = rs2_fwd;
    assign fwd_req.rs1_data_in = {xlen{~rs1_fwd}} & regs[decode_req.rs1_addr];  // zero when forwarded
    assign fwd_req.rs2_data_in = {xlen{~rs2_fwd}} & regs[decode_req.rs2_addr];

    ////////////////////
    // decode response

    assign decode_rsp.rs1_data     = fwd_rsp.rs1_data_out;  // merged in the arbiter
    assign decode_rsp.rs2_data     = fwd_rsp.rs2_data_out;
    assign decode_rsp.rs1_conflict = decode_req.uses_rs1 && rs1_inuse && !rs1_fwd;
    assign decode_rsp.rs2_conflict = decode_req.uses_rs2 && rs2_inuse && !rs2_fwd;

endmodule

`default_nettype wire

/* hw/inuse_scoreboard.sv */
`default_nettype none

// one bit per register, high while an issued instr still owes a result
module inuse_scoreboard (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  clr,             // flush, drops every claim
    input  wire regfile_pkg::reg_addr_t rs1_addr,
    input  wire regfile_pkg::reg_addr_t rs2_addr,
    input  wire regfile_pkg::reg_addr_t decode_rd_addr,
    input  wire regfile_pkg::reg_addr_t wb_rd_addr,
    input  wire logic                  issued,
    input  wire logic                  completed,
    output logic                       rs1_inuse,
    output logic                       rs2_inuse
);

    import regfile_pkg::*;

    logic [reg_count-1:0] inuse;

    ////////////////////
    // update

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inuse <= '0;
        end else if (clr) begin
            inuse <= '0;  // wins over a same-cycle issue
        end else begin
            if (completed) begin
                inuse[wb_rd_addr] <= 1'b0;
            end
            // later assignment, so a new claim beats the completion
            if (issued) begin
                inuse[decode_rd_addr] <= 1'b1;
            end
        end
    end

    ////////////////////
    // lookup

    // plain reads, same cycle as the decode addresses
    assign rs1_inuse = inuse[rs1_addr];
    assign rs2_inuse = inuse[rs2_addr];

endmodule

`default_nettype wire

/* hw/regfile_pkg.sv */
`default_nettype none

package regfile_pkg;

    ////////////////////
    // sizes

    localparam int xlen      = 32;  // data path width
    localparam int reg_count = 32;  // architectural registers, r0 reads zero
    localparam int id_width  = 3;   // issue tag width

    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;  // 5 bits
    typedef logic [id_width-1:0]          instr_id_t;
    typedef logic [xlen-1:0]              data_t;

    ////////////////////
    // decode side

    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        logic      uses_rs1;
        logic      uses_rs2;
        reg_addr_t future_rd_addr;  // destination claimed on issue
        instr_id_t id;
        logic      issued;          // strobe, one per issued instr
    } decode_req_t;

    typedef struct packed {
        data_t rs1_data;
        data_t rs2_data;
        logic  rs1_conflict;  // source still owed a result
        logic  rs2_conflict;
    } decode_rsp_t;

    ////////////////////
    // writeback side

    typedef struct packed {
        logic      valid;
        reg_addr_t rd_addr;
        instr_id_t id;
        data_t     data;
    } unit_result_t;  // 41 bits per unit

    typedef struct packed {
        logic      valid_write;
        reg_addr_t rd_addr;
        instr_id_t id;
        data_t     rd_data;
    } wb_write_t;

    // read data goes out masked, comes back merged with the wb value
    typedef struct packed {
        logic  forward_rs1;
        logic  forward_rs2;
        data_t rs1_data_in;
        data_t rs2_data_in;
    } fwd_req_t;

    typedef struct packed {
        data_t rs1_data_out;
        data_t rs2_data_out;
    } fwd_rsp_t;

endpackage

`default_nettype wire
